//--- include/rv_core_macros.svh
// Core-wide widths, reset address and testbench limits
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Data and address width
`define XLEN 32
// Architectural registers x0 to x31
`define REG_COUNT 32
// First fetch address after reset
`define RESET_PC 32'h8000_0000
// Longest random ready delay from the bus models
`define TB_MAX_STALL 3

`endif

//--- logic/rv_pkgs.sv
// Shared types for the RV32I core
// rv_isa_pkg describes the instruction encoding
// rv_core_pkg describes the core's own control types
`include "rv_core_macros.svh"

package rv_isa_pkg;
	// Register values and byte addresses
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] funct3_t;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_e;
endpackage

package rv_core_pkg;
	// PC without the two always-zero bits
	typedef logic [`XLEN-3:0] pc_t;
	// One strobe per byte lane
	typedef logic [`XLEN/8-1:0] strb_t;

	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEM
	} state_e;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		XOR,
		OR,
		AND
	} alu_op_e;

	// What the datapath does with the instruction
	typedef enum logic [3:0] {
		LUI,
		AUIPC,
		JAL,
		JALR,
		BRANCH,
		LOAD,
		STORE,
		ALU,
		NONE
	} op_class_e;
endpackage

//--- logic/rv_core_ifs.sv
// Internal bundles of the core
// Decoded instruction fields and the register file port

// Fields of the instruction held in the instruction register
interface dec_if;
	rv_core_pkg::op_class_e op_class;
	rv_isa_pkg::funct3_t funct3;
	rv_isa_pkg::word_t imm;
	rv_isa_pkg::reg_addr_t rs1;
	rv_isa_pkg::reg_addr_t rs2;
	rv_isa_pkg::reg_addr_t rd;
	// Instruction bit 30 selects SUB over ADD
	logic alt;
	// Second ALU operand is imm rather than rs2
	logic use_imm;

	modport producer (output op_class, funct3, imm, rs1, rs2, rd, alt, use_imm);
	modport consumer (input op_class, funct3, imm, rs1, rs2, rd, alt, use_imm);
endinterface

// Two read ports and one write port
interface reg_port_if;
	rv_isa_pkg::reg_addr_t ra_addr;
	rv_isa_pkg::word_t ra_data;
	rv_isa_pkg::reg_addr_t rb_addr;
	rv_isa_pkg::word_t rb_data;
	rv_isa_pkg::reg_addr_t rd_addr;
	rv_isa_pkg::word_t rd_data;
	logic rd_wen;

	// Datapath side
	modport client (
		output ra_addr, rb_addr, rd_addr, rd_data, rd_wen,
		input ra_data, rb_data
	);
	// Register file side
	modport server (
		input ra_addr, rb_addr, rd_addr, rd_data, rd_wen,
		output ra_data, rb_data
	);
endinterface

//--- logic/core_ctrl.sv
// Core control FSM
// Sequences fetch, decode, execute and memory access, and owns PC and instruction register
`include "rv_core_macros.svh"

module core_ctrl (
	input logic clock,
	input logic reset,
	input rv_isa_pkg::word_t idata,
	input logic iready,
	output rv_isa_pkg::word_t iaddr,
	output logic ivalid,
	dec_if.consumer dec,
	input rv_isa_pkg::word_t alu_out,
	input logic branch_taken,
	input logic mem_done,
	output rv_core_pkg::state_e state,
	output rv_core_pkg::pc_t pc,
	output rv_isa_pkg::word_t instr
);
	localparam rv_isa_pkg::word_t reset_addr = `RESET_PC;

	rv_core_pkg::pc_t pc_next;
	logic redirect;
	logic mem_op;

	assign iaddr = {pc, 2'b00};
	// Request only while waiting in FETCH
	assign ivalid = (state == rv_core_pkg::FETCH) && !reset;

	// Loads and stores continue into MEM
	assign mem_op = (dec.op_class == rv_core_pkg::LOAD) ||
		(dec.op_class == rv_core_pkg::STORE);

	// Jumps and taken branches go to the ALU sum
	assign redirect = (dec.op_class == rv_core_pkg::JAL) ||
		(dec.op_class == rv_core_pkg::JALR) || branch_taken;
	// Dropping the low bits also clears JALR bit 0
	assign pc_next = redirect ? alu_out[`XLEN-1:2] : pc + rv_core_pkg::pc_t'(1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rv_core_pkg::FETCH;
			pc <= reset_addr[`XLEN-1:2];
		end else begin
			case (state)
				rv_core_pkg::FETCH: begin
					// Hold until the instruction bus accepts
					if (ivalid && iready) begin
						state <= rv_core_pkg::DECODE;
					end
				end
				rv_core_pkg::DECODE: begin
					state <= rv_core_pkg::EXECUTE;
				end
				rv_core_pkg::EXECUTE: begin
					if (mem_op) begin
						state <= rv_core_pkg::MEM;
					end else begin
						pc <= pc_next;
						state <= rv_core_pkg::FETCH;
					end
				end
				rv_core_pkg::MEM: begin
					// Data handshake ends the instruction
					if (mem_done) begin
						pc <= pc_next;
						state <= rv_core_pkg::FETCH;
					end
				end
			endcase
		end
	end

	// Capture the fetched word on the handshake
	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
	end
endmodule

//--- logic/instr_decode.sv
// Instruction decoder
// Classifies the opcode and presents the immediate for that class
module instr_decode (
	input rv_isa_pkg::word_t instr,
	dec_if.producer dec
);
	rv_isa_pkg::funct3_t funct3;
	rv_isa_pkg::word_t imm_i;
	rv_isa_pkg::word_t imm_s;
	rv_isa_pkg::word_t imm_b;
	rv_isa_pkg::word_t imm_j;
	rv_isa_pkg::word_t imm_u;
	logic shift_op;
	logic op_reg_ok;

	assign funct3 = instr[14:12];
	// Shifts are not implemented
	assign shift_op = (funct3[1:0] == 2'b01);
	// funct7 of zero, or SUB
	assign op_reg_ok = (instr[31:25] == 7'b0000000) ||
		((instr[31:25] == 7'b0100000) && (funct3 == 3'b000));

	always_comb begin
		case (instr[6:0])
			rv_isa_pkg::LUI: dec.op_class = rv_core_pkg::LUI;
			rv_isa_pkg::AUIPC: dec.op_class = rv_core_pkg::AUIPC;
			rv_isa_pkg::JAL: dec.op_class = rv_core_pkg::JAL;
			rv_isa_pkg::JALR: dec.op_class = (funct3 == 3'b000) ?
				rv_core_pkg::JALR : rv_core_pkg::NONE;
			// funct3 010 and 011 are not branches
			rv_isa_pkg::BRANCH: dec.op_class = (funct3[2:1] != 2'b01) ?
				rv_core_pkg::BRANCH : rv_core_pkg::NONE;
			rv_isa_pkg::LOAD: dec.op_class =
				(funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ?
				rv_core_pkg::LOAD : rv_core_pkg::NONE;
			rv_isa_pkg::STORE: dec.op_class = (funct3 inside {3'b000, 3'b001, 3'b010}) ?
				rv_core_pkg::STORE : rv_core_pkg::NONE;
			rv_isa_pkg::OP_IMM: dec.op_class = shift_op ?
				rv_core_pkg::NONE : rv_core_pkg::ALU;
			rv_isa_pkg::OP: dec.op_class = (!shift_op && op_reg_ok) ?
				rv_core_pkg::ALU : rv_core_pkg::NONE;
			// Anything else retires as a no-op
			default: dec.op_class = rv_core_pkg::NONE;
		endcase
	end

	// Sign-extended immediates of each format
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};

	always_comb begin
		case (dec.op_class)
			rv_core_pkg::LUI, rv_core_pkg::AUIPC: dec.imm = imm_u;
			rv_core_pkg::JAL: dec.imm = imm_j;
			rv_core_pkg::BRANCH: dec.imm = imm_b;
			rv_core_pkg::STORE: dec.imm = imm_s;
			// JALR, loads and immediate ALU forms
			default: dec.imm = imm_i;
		endcase
	end

	// Register fields sit in fixed places
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];
	assign dec.rd = instr[11:7];
	assign dec.funct3 = funct3;
	assign dec.alt = instr[30];
	assign dec.use_imm = (instr[6:0] == rv_isa_pkg::OP_IMM);
endmodule

//--- logic/exec_unit.sv
// Execute datapath
// Operand select, ALU, comparator and register write-back
module exec_unit (
	input rv_core_pkg::state_e state,
	input rv_core_pkg::pc_t pc,
	dec_if.consumer dec,
	reg_port_if.client rp,
	input logic mem_done,
	input rv_isa_pkg::word_t load_data,
	output rv_isa_pkg::word_t alu_out,
	output logic branch_taken,
	output rv_isa_pkg::word_t store_data
);
	rv_isa_pkg::word_t pc_addr;
	rv_isa_pkg::word_t link_addr;
	rv_isa_pkg::word_t op_a;
	rv_isa_pkg::word_t op_b;
	rv_isa_pkg::word_t cmp_b;
	rv_core_pkg::alu_op_e alu_op;
	logic eq;
	logic lt;
	logic ltu;
	logic cmp_out;
	logic slt_op;
	logic reg_alu;

	assign pc_addr = {pc, 2'b00};
	// Return address for JAL and JALR
	assign link_addr = pc_addr + rv_isa_pkg::word_t'(4);

	// Register reads stay on rs1 and rs2 for the whole instruction
	assign rp.ra_addr = dec.rs1;
	assign rp.rb_addr = dec.rs2;
	assign rp.rd_addr = dec.rd;
	assign store_data = rp.rb_data;

	assign reg_alu = (dec.op_class == rv_core_pkg::ALU) && !dec.use_imm;

	// Operand A is PC for PC-relative forms
	always_comb begin
		case (dec.op_class)
			rv_core_pkg::LUI: op_a = '0;
			rv_core_pkg::AUIPC, rv_core_pkg::JAL, rv_core_pkg::BRANCH: op_a = pc_addr;
			default: op_a = rp.ra_data;
		endcase
	end
	assign op_b = reg_alu ? rp.rb_data : dec.imm;

	always_comb begin
		alu_op = rv_core_pkg::ADD;
		if (dec.op_class == rv_core_pkg::ALU) begin
			case (dec.funct3)
				3'b000: alu_op = (reg_alu && dec.alt) ? rv_core_pkg::SUB : rv_core_pkg::ADD;
				3'b100: alu_op = rv_core_pkg::XOR;
				3'b110: alu_op = rv_core_pkg::OR;
				3'b111: alu_op = rv_core_pkg::AND;
				// SLT forms use the comparator
				default: alu_op = rv_core_pkg::ADD;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			rv_core_pkg::SUB: alu_out = op_a - op_b;
			rv_core_pkg::XOR: alu_out = op_a ^ op_b;
			rv_core_pkg::OR: alu_out = op_a | op_b;
			rv_core_pkg::AND: alu_out = op_a & op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	// Compare rs1 against rs2, or imm for SLTI/SLTIU
	assign cmp_b = (dec.op_class == rv_core_pkg::ALU && dec.use_imm) ? dec.imm : rp.rb_data;
	assign eq = (rp.ra_data == cmp_b);
	assign lt = ($signed(rp.ra_data) < $signed(cmp_b));
	assign ltu = (rp.ra_data < cmp_b);

	always_comb begin
		if (dec.op_class == rv_core_pkg::BRANCH) begin
			case (dec.funct3[2:1])
				2'b00: cmp_out = eq;
				2'b10: cmp_out = lt;
				default: cmp_out = ltu;
			endcase
		end else begin
			// funct3 bit 0 picks SLTU
			cmp_out = dec.funct3[0] ? ltu : lt;
		end
	end
	// BNE, BGE and BGEU invert their base test
	assign branch_taken = (dec.op_class == rv_core_pkg::BRANCH) && (cmp_out ^ dec.funct3[0]);

	assign slt_op = (dec.op_class == rv_core_pkg::ALU) && (dec.funct3[2:1] == 2'b01);

	always_comb begin
		if (state == rv_core_pkg::MEM) begin
			rp.rd_data = load_data;
		end else if (dec.op_class inside {rv_core_pkg::JAL, rv_core_pkg::JALR}) begin
			rp.rd_data = link_addr;
		end else if (slt_op) begin
			rp.rd_data = rv_isa_pkg::word_t'(cmp_out);
		end else begin
			rp.rd_data = alu_out;
		end
	end

	// Results in EXECUTE, load data on the MEM handshake
	always_comb begin
		case (state)
			rv_core_pkg::EXECUTE: rp.rd_wen = dec.op_class inside {rv_core_pkg::LUI,
				rv_core_pkg::AUIPC, rv_core_pkg::JAL, rv_core_pkg::JALR, rv_core_pkg::ALU};
			rv_core_pkg::MEM: rp.rd_wen = (dec.op_class == rv_core_pkg::LOAD) && mem_done;
			default: rp.rd_wen = 1'b0;
		endcase
	end
endmodule

//--- logic/regfile.sv
// Integer register file x0 to x31
// Two combinational reads and one clocked write
`include "rv_core_macros.svh"

module regfile (
	input logic clock,
	input logic reset,
	reg_port_if.server rp
);
	rv_isa_pkg::word_t regs [`REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rp.rd_wen && (rp.rd_addr != '0)) begin
			// Writes to x0 are dropped
			regs[rp.rd_addr] <= rp.rd_data;
		end
	end

	// x0 always reads zero
	assign rp.ra_data = (rp.ra_addr == '0) ? '0 : regs[rp.ra_addr];
	assign rp.rb_data = (rp.rb_addr == '0) ? '0 : regs[rp.rb_addr];
endmodule

//--- logic/dbus_unit.sv
// Data-bus unit
// Issues the MEM request, steers store lanes and extends load data
module dbus_unit (
	input rv_core_pkg::state_e state,
	dec_if.consumer dec,
	input rv_isa_pkg::word_t alu_out,
	input rv_isa_pkg::word_t store_data,
	output rv_isa_pkg::word_t daddr,
	output rv_isa_pkg::word_t dwdata,
	output rv_core_pkg::strb_t dstrb,
	output logic dwrite,
	output logic dvalid,
	input rv_isa_pkg::word_t drdata,
	input logic dready,
	output logic mem_done,
	output rv_isa_pkg::word_t load_data
);
	logic [1:0] offset;
	logic [7:0] lane_byte;
	logic [15:0] lane_half;
	logic sign_ext;

	// Byte offset inside the word
	assign offset = alu_out[1:0];

	assign dvalid = (state == rv_core_pkg::MEM);
	assign dwrite = dvalid && (dec.op_class == rv_core_pkg::STORE);
	// Bus address is word aligned
	assign daddr = alu_out & ~rv_isa_pkg::word_t'(3);
	assign mem_done = dvalid && dready;

	// Replicate narrow data across all lanes
	always_comb begin
		case (dec.funct3[1:0])
			2'b00: begin
				dwdata = {4{store_data[7:0]}};
				dstrb = 4'b0001 << offset;
			end
			2'b01: begin
				dwdata = {2{store_data[15:0]}};
				dstrb = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dwdata = store_data;
				dstrb = 4'b1111;
			end
		endcase
	end

	// Pick the addressed lane
	assign lane_byte = drdata[{offset, 3'b000} +: 8];
	assign lane_half = offset[1] ? drdata[31:16] : drdata[15:0];
	// LBU and LHU have funct3 bit 2 set
	assign sign_ext = !dec.funct3[2];

	always_comb begin
		case (dec.funct3[1:0])
			2'b00: load_data = {{24{sign_ext && lane_byte[7]}}, lane_byte};
			2'b01: load_data = {{16{sign_ext && lane_half[15]}}, lane_half};
			default: load_data = drdata;
		endcase
	end
endmodule

//--- logic/rv_core.sv
// RV32I multi-cycle core top level
// Connects control, decode, datapath, register file and data-bus unit
module rv_core (
	input logic clock,
	input logic reset,
	output rv_isa_pkg::word_t iaddr,
	input rv_isa_pkg::word_t idata,
	output logic ivalid,
	input logic iready,
	output rv_isa_pkg::word_t daddr,
	output rv_isa_pkg::word_t dwdata,
	input rv_isa_pkg::word_t drdata,
	output rv_core_pkg::strb_t dstrb,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);
	rv_core_pkg::state_e state;
	rv_core_pkg::pc_t pc;
	rv_isa_pkg::word_t instr;
	rv_isa_pkg::word_t alu_out;
	logic branch_taken;
	rv_isa_pkg::word_t store_data;
	logic mem_done;
	rv_isa_pkg::word_t load_data;

	dec_if dec ();
	reg_port_if rp ();

	core_ctrl u_core_ctrl (
		.clock        (clock),
		.reset        (reset),
		.idata        (idata),
		.iready       (iready),
		.iaddr        (iaddr),
		.ivalid       (ivalid),
		.dec          (dec.consumer),
		.alu_out      (alu_out),
		.branch_taken (branch_taken),
		.mem_done     (mem_done),
		.state        (state),
		.pc           (pc),
		.instr        (instr)
	);

	instr_decode u_instr_decode (
		.instr (instr),
		.dec   (dec.producer)
	);

	exec_unit u_exec_unit (
		.state        (state),
		.pc           (pc),
		.dec          (dec.consumer),
		.rp           (rp.client),
		.mem_done     (mem_done),
		.load_data    (load_data),
		.alu_out      (alu_out),
		.branch_taken (branch_taken),
		.store_data   (store_data)
	);

	regfile u_regfile (
		.clock (clock),
		.reset (reset),
		.rp    (rp.server)
	);

	dbus_unit u_dbus_unit (
		.state      (state),
		.dec        (dec.consumer),
		.alu_out    (alu_out),
		.store_data (store_data),
		.daddr      (daddr),
		.dwdata     (dwdata),
		.dstrb      (dstrb),
		.dwrite     (dwrite),
		.dvalid     (dvalid),
		.drdata     (drdata),
		.dready     (dready),
		.mem_done   (mem_done),
		.load_data  (load_data)
	);
endmodule

//--- dv/rv_core_assertions.sv
// Bus protocol checks for the core's instruction and data ports
// Bound into rv_core
module rv_core_assertions (
	input logic clock,
	input logic reset,
	input logic ivalid,
	input logic iready,
	input logic [31:0] iaddr,
	input logic dvalid,
	input logic dready,
	input logic [31:0] daddr,
	input logic [3:0] dstrb,
	input logic dwrite
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertion count
	int fail_count = 0;

	// Only one bus active at a time
	bus_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(ivalid && dvalid))
		else begin
			fail_count++;
			$error("ivalid and dvalid high together");
		end

	// Fetch request holds until accepted
	fetch_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else begin
			fail_count++;
			$error("fetch request changed before iready");
		end

	data_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dstrb))
		else begin
			fail_count++;
			$error("data request changed before dready");
		end

	// A write always enables some lane
	write_strobe: assert property (@(posedge clock) disable iff (reset)
		dwrite |-> dstrb != 4'b0000)
		else begin
			fail_count++;
			$error("dwrite with empty dstrb");
		end
endmodule

bind rv_core rv_core_assertions u_assertions (
	.clock  (clock),
	.reset  (reset),
	.ivalid (ivalid),
	.iready (iready),
	.iaddr  (iaddr),
	.dvalid (dvalid),
	.dready (dready),
	.daddr  (daddr),
	.dstrb  (dstrb),
	.dwrite (dwrite)
);

//--- dv/rv_core_tb.sv
// Testbench for the RV32I core
// Memory models with random back-pressure, store checks against the vectors file
`include "rv_core_macros.svh"

module rv_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Sections of the vectors file
	localparam int prog_base = 'h010;
	localparam int data_base = 'h080;
	localparam int store_base = 'h090;
	localparam int check_base = 'h140;
	localparam int dmem_words = 64;
	localparam int stall_bits = $clog2(`TB_MAX_STALL + 1);

	logic clock;
	logic reset;
	rv_isa_pkg::word_t iaddr;
	rv_isa_pkg::word_t idata;
	logic ivalid;
	logic iready;
	rv_isa_pkg::word_t daddr;
	rv_isa_pkg::word_t dwdata;
	rv_isa_pkg::word_t drdata;
	rv_core_pkg::strb_t dstrb;
	logic dwrite;
	logic dvalid;
	logic dready;

	logic [31:0] vec [0:511];
	logic [31:0] imem [0:127];
	logic [31:0] dmem [0:dmem_words-1];
	logic [31:0] lfsr;
	int prog_count;
	int store_count;
	int check_count;
	int store_idx;
	int istall;
	int dstall;
	int error_count;
	int test_mark;
	int tests_run;
	int tests_failed;
	int cycle_count;
	int cycle_limit;
	int assert_fails;
	logic first_fetch;
	logic done;
	logic timed_out;
	logic run_ended;

	rv_core dut (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dstrb  (dstrb),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	always #10 clock = ~clock;

	// Run limit from the program length
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			timed_out = 1'b1;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hd000_0001;
		end
		return s >> 1;
	endfunction

	// One LFSR step per delay bit
	task automatic pick_stall(output int n);
		int v;
		v = 0;
		for (int i = 0; i < stall_bits; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		n = (v > `TB_MAX_STALL) ? `TB_MAX_STALL : v;
	endtask

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		n = error_count - test_mark;
		test_mark = error_count;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
			$display("test %s: %0d errors", name, n);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	function automatic string group_name(input logic [31:0] g);
		case (g)
			1: return "arithmetic";
			2: return "control flow";
			3: return "loads";
			4: return "store lanes";
			default: return "unknown group";
		endcase
	endfunction

	// Word index into data memory or -1 outside the window at 0x1000
	function automatic int dmem_index(input logic [31:0] a);
		if (a[31:8] != 24'h000010) begin
			return -1;
		end
		return int'(a[7:2]);
	endfunction

	task automatic record_store();
		int e;
		int idx;
		if (store_idx >= store_count) begin
			error_count++;
			$display("unexpected extra store %0d to address %h with data %h",
				store_idx, daddr, dwdata);
		end else begin
			e = store_base + store_idx * 4;
			check_equal("store address", daddr, vec[e]);
			check_equal("store data", dwdata, vec[e + 1]);
			check_equal("store strobe", {28'h0, dstrb}, vec[e + 2]);
			// Group ends at the list end or a group change
			if (store_idx == store_count - 1 || vec[e + 7] != vec[e + 3]) begin
				finish_test(group_name(vec[e + 3]));
			end
		end
		idx = dmem_index(daddr);
		if (idx < 0) begin
			error_count++;
			$display("store to address %h is outside data memory", daddr);
		end else begin
			for (int b = 0; b < 4; b++) begin
				if (dstrb[b]) begin
					dmem[idx][8*b +: 8] = dwdata[8*b +: 8];
				end
			end
		end
		store_idx++;
	endtask

	// Bus models drive ready and read data on the falling edge
	always @(negedge clock) begin
		if (iready) begin
			iready = 1'b0;
			pick_stall(istall);
		end else if (ivalid) begin
			if (istall == 0) begin
				iready = 1'b1;
				if (iaddr < `RESET_PC || iaddr >= `RESET_PC + prog_count * 4) begin
					error_count++;
					$display("fetch from address %h is outside the program", iaddr);
					idata = 32'h0000_0013;
				end else begin
					idata = imem[(iaddr - `RESET_PC) >> 2];
				end
			end else begin
				istall--;
			end
		end
		if (dready) begin
			dready = 1'b0;
			pick_stall(dstall);
		end else if (dvalid) begin
			if (dstall == 0) begin
				dready = 1'b1;
				if (dmem_index(daddr) < 0) begin
					drdata = 32'hbad0_0000 ^ daddr;
				end else begin
					drdata = dmem[dmem_index(daddr)];
				end
			end else begin
				dstall--;
			end
		end
	end

	// Monitor on the rising edge
	always @(posedge clock) begin
		if (!reset) begin
			if (!first_fetch && ivalid) begin
				check_equal("first fetch address", iaddr, `RESET_PC);
				first_fetch = 1'b1;
				finish_test("reset");
			end
			if (!dvalid) begin
				check_equal("dwrite outside MEM", {31'h0, dwrite}, 32'h0);
			end
			if (ivalid && iready && iaddr == `RESET_PC + (prog_count - 1) * 4) begin
				done = 1'b1;
			end
			if (dvalid && dready && dwrite) begin
				record_store();
			end
		end
	end

	initial begin
		int idx;
		clock = 1'b0;
		reset = 1'b1;
		iready = 1'b0;
		dready = 1'b0;
		idata = '0;
		drdata = '0;
		lfsr = 32'hb3cf_1a6a;
		store_idx = 0;
		error_count = 0;
		test_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		cycle_limit = 0;
		assert_fails = 0;
		first_fetch = 1'b0;
		done = 1'b0;
		timed_out = 1'b0;
		run_ended = 1'b0;

		$readmemh("dv/rv_core_vectors.txt", vec);
		prog_count = int'(vec[0]);
		store_count = int'(vec[2]);
		check_count = int'(vec[3]);
		for (int i = 0; i < prog_count; i++) begin
			imem[i] = vec[prog_base + i];
		end
		// Unloaded words carry their own address
		for (int i = 0; i < dmem_words; i++) begin
			dmem[i] = 32'h5a5a_0000 ^ (32'h1000 + i * 4);
		end
		for (int i = 0; i < int'(vec[1]); i++) begin
			dmem[i] = vec[data_base + i];
		end
		cycle_limit = 4 * (`TB_MAX_STALL + 1) * prog_count + 50;
		pick_stall(istall);
		pick_stall(dstall);

		repeat (2) @(posedge clock);
		@(negedge clock);
		// Both buses idle while reset is held
		check_equal("ivalid in reset", {31'h0, ivalid}, 32'h0);
		check_equal("dvalid in reset", {31'h0, dvalid}, 32'h0);
		check_equal("dwrite in reset", {31'h0, dwrite}, 32'h0);
		reset = 1'b0;

		while (!done && !timed_out) begin
			@(posedge clock);
		end
		if (timed_out) begin
			$display("timeout: program did not reach its last word within %0d cycles",
				cycle_limit);
		end else begin
			repeat (4) @(posedge clock);
			check_equal("store count", store_idx, store_count);
			finish_test("store sequence under back-pressure");
			for (int c = 0; c < check_count; c++) begin
				idx = dmem_index(vec[check_base + 2 * c]);
				if (idx < 0) begin
					error_count++;
					$display("memory check address %h is outside data memory",
						vec[check_base + 2 * c]);
				end else begin
					check_equal("merged memory word", dmem[idx], vec[check_base + 2 * c + 1]);
				end
			end
			finish_test("memory merge");
		end
		assert_fails = dut.u_assertions.fail_count;
		if (assert_fails != 0) begin
			$display("%0d bus protocol assertions failed", assert_fails);
		end
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, assert_fails);
		run_ended = 1'b1;
		if (error_count == 0 && !timed_out && assert_fails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Run stopped early, for example by an assertion
	final begin
		if (!run_ended) begin
			$display("*** FAILED ***");
		end
	end
endmodule

//--- rv_core.f
+incdir+include
logic/rv_pkgs.sv
logic/rv_core_ifs.sv
logic/core_ctrl.sv
logic/instr_decode.sv
logic/exec_unit.sv
logic/regfile.sv
logic/dbus_unit.sv
logic/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
	echo "could not create build directory"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	--top-module rv_core_tb -f rv_core.f \
	--Mdir build/obj -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./build/obj/rv_core_sim > build/sim.log 2>&1
sim_status=$?
cat build/sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi

if grep -q "\*\*\* PASSED \*\*\*" build/sim.log; then
	exit 0
fi
exit 1

//--- dv/rv_core_vectors.txt
// Counts: program words, data preload words, expected stores, memory checks
// Program from 0x010, preload from 0x080, stores from 0x090 as addr data strb group
// Memory checks from 0x140 as addr value
@000
00000055 00000002 00000024 00000002
// Program at RESET_PC, eight words per line
@010
000010B7 00500113 FFD00193 00310533 04A0A023 40310533 04A0A223 00314533
04A0A423 00316533 04A0A623 00317533 04A0A823 0021A533 04A0AA23 0021B533
04A0AC23 FFF14513 04A0AE23 7F016513 06A0A023 FF01F513 06A0A223 FFE1A513
06A0A423 FFF13513 06A0A623 ABCDE537 06A0A823 00001517 06A0AA23 00210463
0620AC23 00211463 0620AE23 0021C463 0620AC23 0021D463 0820A023 00316463
0620AC23 00317463 0820A223 00310463 0820A423 00311463 0620AC23 00314463
0820A623 00315463 0620AC23 0021E463 0820A823 0021F463 0620AC23 0080056F
0620AC23 08A0AA23 00000617 00D60567 0620AC23 08A0AC23 00008503 08A0AE23
00308503 0AA0A023 0020C503 0AA0A223 0010C503 0AA0A423 00209503 0AA0A623
0000D503 0AA0A823 00009503 0AA0AA23 0040A503 0AA0AC23 0CA08023 0CA080A3
0CA08123 0CA081A3 0CA09223 0CA09323 0000006F
// Data preload at 0x1000
@080
80FF7F01 12345678
// Arithmetic, logic, compare, LUI and AUIPC
@090
00001040 00000002 0000000F 00000001  00001044 00000008 0000000F 00000001
00001048 FFFFFFF8 0000000F 00000001  0000104C FFFFFFFD 0000000F 00000001
00001050 00000005 0000000F 00000001  00001054 00000001 0000000F 00000001
00001058 00000000 0000000F 00000001  0000105C FFFFFFFA 0000000F 00000001
00001060 000007F5 0000000F 00000001  00001064 FFFFFFF0 0000000F 00000001
00001068 00000001 0000000F 00000001  0000106C 00000001 0000000F 00000001
00001070 ABCDE000 0000000F 00000001  00001074 80001074 0000000F 00000001
// Branch markers and link values
0000107C 00000005 0000000F 00000002  00001080 00000005 0000000F 00000002
00001084 00000005 0000000F 00000002  00001088 00000005 0000000F 00000002
0000108C 00000005 0000000F 00000002  00001090 00000005 0000000F 00000002
00001094 800000E0 0000000F 00000002  00001098 800000F0 0000000F 00000002
// Load results
0000109C 00000001 0000000F 00000003  000010A0 FFFFFF80 0000000F 00000003
000010A4 000000FF 0000000F 00000003  000010A8 0000007F 0000000F 00000003
000010AC FFFF80FF 0000000F 00000003  000010B0 00007F01 0000000F 00000003
000010B4 00007F01 0000000F 00000003  000010B8 12345678 0000000F 00000003
// Byte and halfword store lanes
000010C0 78787878 00000001 00000004  000010C0 78787878 00000002 00000004
000010C0 78787878 00000004 00000004  000010C0 78787878 00000008 00000004
000010C4 56785678 00000003 00000004  000010C4 56785678 0000000C 00000004
// Words after strobe merge
@140
000010C0 78787878 000010C4 56785678
